// ==== src/conv_dp_pkg.sv ====
package conv_dp_pkg;

    //////////////////////////////////////////////////
    // image and kernel geometry
    //////////////////////////////////////////////////

    localparam int img_w  = 8;
    localparam int img_h  = 8;
    localparam int k_size = 3;
    localparam int n_taps = k_size * k_size;
    localparam int col_w  = $clog2(img_w);
    localparam int row_w  = $clog2(img_h);

    localparam int pix_w   = 8;
    localparam int wt_w    = 2;
    localparam int scale_w = 8;
    localparam int sum_w   = 13; // nine taps of +/-255
    localparam int res_w   = 21;

    localparam int n_pix = img_w * img_h;
    localparam int n_res = (img_w - k_size + 1) * (img_h - k_size + 1);

    // 00 and 10 both mean a zero weight
    localparam logic [wt_w-1:0] wt_pos = 2'b01;
    localparam logic [wt_w-1:0] wt_neg = 2'b11;

    typedef logic [$clog2(n_pix)-1:0] pix_addr_t;
    typedef logic [5:0]               res_addr_t;

    //////////////////////////////////////////////////
    // datapath payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic             valid;
        logic             win_ok; // row and col both past the kernel edge
        logic [pix_w-1:0] data;
    } pix_t;

    typedef struct packed {
        logic                         valid;
        logic [n_taps-1:0][pix_w-1:0] taps; // tap 3*row + col
    } win_t;

    typedef struct packed {
        logic                    valid;
        logic signed [res_w-1:0] data;
    } res_t;

    typedef struct packed {
        logic             en;
        pix_addr_t        addr;
        logic [pix_w-1:0] data;
    } feat_wr_t;

endpackage

// ==== src/conv_cfg_pkg.sv ====
package conv_cfg_pkg;

    //////////////////////////////////////////////////
    // apb register map
    //////////////////////////////////////////////////

    localparam int apb_aw = 12;
    localparam int apb_dw = 32;

    localparam logic [apb_aw-1:0] addr_ctrl    = 12'h000; // bit 0 starts a run
    localparam logic [apb_aw-1:0] addr_status  = 12'h004; // {done, busy}
    localparam logic [apb_aw-1:0] addr_weights = 12'h008;
    localparam logic [apb_aw-1:0] addr_scale   = 12'h00C;

    // write-only feature words 4 bytes apart
    localparam logic [apb_aw-1:0] feat_base = 12'h100;
    // sign-extended read-only result words
    localparam logic [apb_aw-1:0] res_base  = 12'h200;

    // nine ternary codes with tap 0 in the low bits
    localparam int wt_bits = conv_dp_pkg::n_taps * conv_dp_pkg::wt_w;

    //////////////////////////////////////////////////
    // run configuration
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [wt_bits-1:0]              weights;
        logic [conv_dp_pkg::scale_w-1:0] scale;
    } conv_cfg_t;

endpackage

// ==== src/conv_regs.sv ====
module conv_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [conv_cfg_pkg::apb_aw-1:0]  paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [conv_cfg_pkg::apb_dw-1:0]  pwdata,
    output logic [conv_cfg_pkg::apb_dw-1:0]  prdata,
    output logic                             pready,
    output logic                             pslverr,
    output conv_dp_pkg::feat_wr_t            feat_wr,
    output conv_cfg_pkg::conv_cfg_t          cfg,
    output logic                             start,
    input  conv_dp_pkg::res_t                res
);

    logic access;
    logic wr;
    logic hit_ctrl;
    logic hit_status;
    logic hit_weights;
    logic hit_scale;
    logic hit_feat;
    logic hit_res;
    logic mapped;
    conv_dp_pkg::pix_addr_t word_idx;

    logic busy;
    logic done;
    conv_dp_pkg::res_addr_t res_idx;
    logic signed [conv_dp_pkg::res_w-1:0] res_mem [conv_dp_pkg::n_res];

    //////////////////////////////////////////////////
    // apb decode
    //////////////////////////////////////////////////

    assign access   = psel && penable;
    assign wr       = access && pwrite;
    assign word_idx = paddr[7:2];

    assign hit_ctrl    = (paddr == conv_cfg_pkg::addr_ctrl);
    assign hit_status  = (paddr == conv_cfg_pkg::addr_status);
    assign hit_weights = (paddr == conv_cfg_pkg::addr_weights);
    assign hit_scale   = (paddr == conv_cfg_pkg::addr_scale);
    assign hit_feat    = (paddr[11:8] == conv_cfg_pkg::feat_base[11:8]) && (paddr[1:0] == 2'b00);
    assign hit_res     = (paddr[11:8] == conv_cfg_pkg::res_base[11:8]) && (paddr[1:0] == 2'b00)
                         && (word_idx < conv_dp_pkg::pix_addr_t'(conv_dp_pkg::n_res));

    assign mapped  = hit_ctrl || hit_status || hit_weights || hit_scale || hit_feat || hit_res;
    assign pready  = 1'b1; // no wait states
    assign pslverr = access && (!mapped || (hit_res && pwrite));

    // feature writes land in the scanner at the access edge
    assign feat_wr.en   = wr && hit_feat && !busy;
    assign feat_wr.addr = word_idx;
    assign feat_wr.data = pwdata[conv_dp_pkg::pix_w-1:0];

    always_comb
    begin
        prdata = '0;
        if (hit_status)
            prdata[1:0] = {done, busy};
        else if (hit_weights)
            prdata[conv_cfg_pkg::wt_bits-1:0] = cfg.weights;
        else if (hit_scale)
            prdata[conv_dp_pkg::scale_w-1:0] = cfg.scale;
        else if (hit_res)
            prdata = {{(conv_cfg_pkg::apb_dw - conv_dp_pkg::res_w)
                         {res_mem[word_idx][conv_dp_pkg::res_w-1]}},
                      res_mem[word_idx]};
    end

    //////////////////////////////////////////////////
    // control and status
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cfg     <= '0;
            start   <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            res_idx <= '0;
        end
        else
        begin
            start <= 1'b0;
            if (wr && hit_weights)
                cfg.weights <= pwdata[conv_cfg_pkg::wt_bits-1:0];
            if (wr && hit_scale)
                cfg.scale <= pwdata[conv_dp_pkg::scale_w-1:0];

            if (wr && hit_ctrl && pwdata[0] && !busy)
            begin
                start   <= 1'b1;
                busy    <= 1'b1;
                done    <= 1'b0;
                res_idx <= '0;
            end
            else if (res.valid)
            begin
                res_idx <= res_idx + 1'b1;
                if (res_idx == conv_dp_pkg::res_addr_t'(conv_dp_pkg::n_res - 1))
                begin
                    busy <= 1'b0; // last result just stored
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (res.valid)
            res_mem[res_idx] <= res.data;
    end

    a_res_in_run: assert property (@(posedge clk) disable iff (!rst_n) res.valid |-> busy)
        else $error("result arrived outside a run");

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n) $rose(penable) |-> psel)
        else $error("penable rose without psel");

endmodule

// ==== src/feature_scan.sv ====
module feature_scan (
    input  logic                  clk,
    input  logic                  rst_n,
    input  conv_dp_pkg::feat_wr_t feat_wr,
    input  logic                  start,
    output conv_dp_pkg::pix_t     pix
);

    logic [conv_dp_pkg::pix_w-1:0] mem [conv_dp_pkg::n_pix];

    conv_dp_pkg::pix_addr_t          rd_cnt;
    logic                            running;
    logic [conv_dp_pkg::row_w-1:0]   rd_row;
    logic [conv_dp_pkg::col_w-1:0]   rd_col;

    logic                            pix_valid;
    logic                            pix_win_ok;
    logic [conv_dp_pkg::pix_w-1:0]   pix_data;

    // in raster order row and col are just fields of the count
    assign rd_col = rd_cnt[conv_dp_pkg::col_w-1:0];
    assign rd_row = rd_cnt[conv_dp_pkg::col_w +: conv_dp_pkg::row_w];

    //////////////////////////////////////////////////
    // feature memory with one write and one read port
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (feat_wr.en)
            mem[feat_wr.addr] <= feat_wr.data;
        pix_data <= mem[rd_cnt]; // 1 cycle read
    end

    //////////////////////////////////////////////////
    // read sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_cnt     <= '0;
            running    <= 1'b0;
            pix_valid  <= 1'b0;
            pix_win_ok <= 1'b0;
        end
        else if (start || running)
        begin
            rd_cnt     <= rd_cnt + 1'b1; // wraps to 0 after the last pixel
            running    <= (rd_cnt != conv_dp_pkg::pix_addr_t'(conv_dp_pkg::n_pix - 1));
            pix_valid  <= 1'b1;
            pix_win_ok <= (int'(rd_row) >= conv_dp_pkg::k_size - 1)
                          && (int'(rd_col) >= conv_dp_pkg::k_size - 1);
        end
        else
        begin
            pix_valid  <= 1'b0;
            pix_win_ok <= 1'b0;
        end
    end

    assign pix = '{valid: pix_valid, win_ok: pix_win_ok, data: pix_data};

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) start |-> !running)
        else $error("start during a scan");

endmodule

// ==== src/window_buffer.sv ====
module window_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  conv_dp_pkg::pix_t pix,
    output conv_dp_pkg::win_t win
);

    // line_buf[0] holds the previous row and line_buf[1] the one before
    logic [conv_dp_pkg::pix_w-1:0] line_buf [2][conv_dp_pkg::img_w];
    logic [conv_dp_pkg::pix_w-1:0] row_in [conv_dp_pkg::k_size];
    logic [conv_dp_pkg::n_taps-1:0][conv_dp_pkg::pix_w-1:0] taps;
    logic win_valid;

    always_comb
    begin
        row_in[0] = line_buf[1][conv_dp_pkg::img_w-1];
        row_in[1] = line_buf[0][conv_dp_pkg::img_w-1];
        row_in[2] = pix.data; // current row
    end

    //////////////////////////////////////////////////
    // line buffers and taps
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (pix.valid)
        begin
            line_buf[0][0] <= pix.data;
            line_buf[1][0] <= line_buf[0][conv_dp_pkg::img_w-1];
            for (int b = 0; b < 2; b++)
            begin
                for (int n = 1; n < conv_dp_pkg::img_w; n++)
                    line_buf[b][n] <= line_buf[b][n-1];
            end

            // newest pixel enters at the right column
            for (int i = 0; i < conv_dp_pkg::k_size; i++)
            begin
                for (int j = 0; j < conv_dp_pkg::k_size - 1; j++)
                    taps[i*conv_dp_pkg::k_size + j] <= taps[i*conv_dp_pkg::k_size + j + 1];
                taps[i*conv_dp_pkg::k_size + conv_dp_pkg::k_size - 1] <= row_in[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            win_valid <= 1'b0;
        else
            win_valid <= pix.valid && pix.win_ok;
    end

    assign win = '{valid: win_valid, taps: taps};

endmodule

// ==== src/ternary_mac.sv ====
module ternary_mac (
    input  logic                    clk,
    input  logic                    rst_n,
    input  conv_dp_pkg::win_t       win,
    input  conv_cfg_pkg::conv_cfg_t cfg,
    output conv_dp_pkg::res_t       res
);

    logic signed [conv_dp_pkg::sum_w-1:0] acc;
    logic signed [conv_dp_pkg::sum_w-1:0] s1_sum;
    logic                                 s1_valid;
    logic signed [conv_dp_pkg::res_w-1:0] res_data;
    logic                                 res_valid;

    //////////////////////////////////////////////////
    // stage one ternary dot product
    //////////////////////////////////////////////////

    always_comb
    begin
        acc = '0;
        for (int n = 0; n < conv_dp_pkg::n_taps; n++)
        begin
            case (cfg.weights[n*conv_dp_pkg::wt_w +: conv_dp_pkg::wt_w])
                conv_dp_pkg::wt_pos:
                    acc = acc + {{(conv_dp_pkg::sum_w - conv_dp_pkg::pix_w){1'b0}}, win.taps[n]};
                conv_dp_pkg::wt_neg:
                    acc = acc - {{(conv_dp_pkg::sum_w - conv_dp_pkg::pix_w){1'b0}}, win.taps[n]};
                default:
                    acc = acc; // zero weight
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        s1_sum <= acc;
        // widen the unsigned scale before the signed multiply
        res_data <= s1_sum * $signed({1'b0, cfg.scale});
    end

    //////////////////////////////////////////////////
    // valid pipeline
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            s1_valid  <= win.valid;
            res_valid <= s1_valid;
        end
    end

    assign res = '{valid: res_valid, data: res_data};

endmodule

// ==== src/conv_top.sv ====
module conv_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [conv_cfg_pkg::apb_aw-1:0]  paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [conv_cfg_pkg::apb_dw-1:0]  pwdata,
    output logic [conv_cfg_pkg::apb_dw-1:0]  prdata,
    output logic                             pready,
    output logic                             pslverr
);

    conv_dp_pkg::feat_wr_t   feat_wr;
    conv_cfg_pkg::conv_cfg_t cfg;
    logic                    start;
    conv_dp_pkg::pix_t       pix;
    conv_dp_pkg::win_t       win;
    conv_dp_pkg::res_t       res;

    conv_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .feat_wr (feat_wr),
        .cfg     (cfg),
        .start   (start),
        .res     (res)
    );

    feature_scan u_scan (.clk(clk), .rst_n(rst_n), .feat_wr(feat_wr), .start(start), .pix(pix));

    window_buffer u_win (.clk(clk), .rst_n(rst_n), .pix(pix), .win(win));

    ternary_mac u_mac (.clk(clk), .rst_n(rst_n), .win(win), .cfg(cfg), .res(res));

endmodule

// ==== bench/conv_tests.svh ====
`ifndef conv_tests_svh
`define conv_tests_svh

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////

function automatic int weight_value(input logic [conv_dp_pkg::wt_w-1:0] code);
    case (code)
        2'b01:   return 1;
        2'b11:   return -1;
        default: return 0; // 00 and 10
    endcase
endfunction

function automatic int model_conv(input int r, input int c);
    int sum;
    int tap;
    sum = 0;
    for (int i = 0; i < conv_dp_pkg::k_size; i++)
    begin
        for (int j = 0; j < conv_dp_pkg::k_size; j++)
        begin
            tap = 3 * i + j;
            sum += weight_value(wts[2*tap +: 2]) * img[(r + i) * conv_dp_pkg::img_w + c + j];
        end
    end
    return sum * int'(scl);
endfunction

//////////////////////////////////////////////////
// run helpers
//////////////////////////////////////////////////

task automatic load_setup();
    logic err;
    for (int i = 0; i < conv_dp_pkg::n_pix; i++)
        apb_write(conv_cfg_pkg::feat_base + 12'(4 * i), 32'(img[i]), err);
    apb_write(conv_cfg_pkg::addr_weights, 32'(wts), err);
    apb_write(conv_cfg_pkg::addr_scale, 32'(scl), err);
endtask

task automatic wait_done(input string name);
    logic [31:0] word;
    logic        err;
    int          polls;
    word  = '0;
    polls = 0;
    while (!word[1] && polls < max_polls)
    begin
        apb_read(conv_cfg_pkg::addr_status, word, err);
        polls++;
    end
    if (!word[1])
    begin
        $display("%s: done never set after %0d status polls", name, polls);
        other_errors++;
    end
    check_word({name, " status"}, 32'h2, word); // idle and done
endtask

task automatic compare_results(input string name);
    logic [31:0] word;
    logic        err;
    int          expected;
    for (int idx = 0; idx < conv_dp_pkg::n_res; idx++)
    begin
        expected = model_conv(idx / 6, idx % 6);
        apb_read(conv_cfg_pkg::res_base + 12'(4 * idx), word, err);
        check_res($sformatf("%s res %0d", name, idx), conv_dp_pkg::res_w'(expected),
                  word[conv_dp_pkg::res_w-1:0]);
        check_word($sformatf("%s word %0d", name, idx), expected, word);
    end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic test_reset_regs();
    logic [31:0] word;
    logic        err;
    apb_read(conv_cfg_pkg::addr_status, word, err);
    check_word("reset status", 32'h0, word);
    expect_slverr("reset status", 1'b0, err);
    apb_read(conv_cfg_pkg::addr_weights, word, err);
    check_word("reset weights", 32'h0, word);
    apb_read(conv_cfg_pkg::addr_scale, word, err);
    check_word("reset scale", 32'h0, word);
    wts = conv_cfg_pkg::wt_bits'($urandom());
    scl = conv_dp_pkg::scale_w'($urandom());
    apb_write(conv_cfg_pkg::addr_weights, 32'(wts), err);
    apb_write(conv_cfg_pkg::addr_scale, 32'(scl), err);
    apb_read(conv_cfg_pkg::addr_weights, word, err);
    check_word("weights readback", 32'(wts), word);
    apb_read(conv_cfg_pkg::addr_scale, word, err);
    check_word("scale readback", 32'(scl), word);
    apb_read(12'h010, word, err);
    expect_slverr("unmapped read", 1'b1, err);
    apb_write(12'h300, 32'h1, err);
    expect_slverr("unmapped write", 1'b1, err);
endtask

task automatic test_centre_ramp();
    logic [31:0] word;
    logic        err;
    for (int i = 0; i < conv_dp_pkg::n_pix; i++)
        img[i] = 3 * i;
    wts = 18'h00100; // only tap 4 at +1
    scl = 8'd1;
    load_setup();
    apb_write(conv_cfg_pkg::addr_ctrl, 32'h1, err);
    wait_done("centre ramp");
    for (int idx = 0; idx < conv_dp_pkg::n_res; idx++)
    begin
        apb_read(conv_cfg_pkg::res_base + 12'(4 * idx), word, err);
        check_res($sformatf("centre ramp res %0d", idx),
                  conv_dp_pkg::res_w'(img[(idx / 6 + 1) * conv_dp_pkg::img_w + idx % 6 + 1]),
                  word[conv_dp_pkg::res_w-1:0]);
    end
endtask

task automatic test_random_image();
    logic err;
    for (int i = 0; i < conv_dp_pkg::n_pix; i++)
        img[i] = int'($urandom_range(255, 0));
    for (int t = 0; t < conv_dp_pkg::n_taps; t++)
        wts[2*t +: 2] = 2'($urandom());
    wts[1:0]   = 2'b01;
    wts[5:4]   = 2'b10; // the other zero code
    wts[17:16] = 2'b11;
    scl = conv_dp_pkg::scale_w'($urandom_range(255, 1));
    load_setup();
    apb_write(conv_cfg_pkg::addr_ctrl, 32'h1, err);
    wait_done("random image");
    compare_results("random image");
endtask

task automatic test_most_negative();
    logic [31:0] word;
    logic        err;
    int          most_neg;
    most_neg = -9 * 255 * 255;
    for (int i = 0; i < conv_dp_pkg::n_pix; i++)
        img[i] = 255;
    wts = 18'h3FFFF; // all -1
    scl = 8'd255;
    load_setup();
    apb_write(conv_cfg_pkg::addr_ctrl, 32'h1, err);
    wait_done("most negative");
    for (int idx = 0; idx < conv_dp_pkg::n_res; idx++)
    begin
        apb_read(conv_cfg_pkg::res_base + 12'(4 * idx), word, err);
        check_word($sformatf("most negative word %0d", idx), most_neg, word);
    end
endtask

task automatic test_busy_ignored();
    logic [31:0] word;
    logic        err;
    for (int i = 0; i < conv_dp_pkg::n_pix; i++)
        img[i] = int'($urandom_range(255, 0));
    for (int t = 0; t < conv_dp_pkg::n_taps; t++)
        wts[2*t +: 2] = 2'($urandom());
    wts[17:16] = 2'b01; // bottom right tap sees the last pixel
    scl = conv_dp_pkg::scale_w'($urandom_range(255, 1));
    load_setup();
    apb_write(conv_cfg_pkg::addr_ctrl, 32'h1, err);
    apb_read(conv_cfg_pkg::addr_status, word, err);
    check_word("busy ignored status", 32'h1, word);
    // the scan has not reached the last row yet
    for (int i = conv_dp_pkg::n_pix - 4; i < conv_dp_pkg::n_pix; i++)
        apb_write(conv_cfg_pkg::feat_base + 12'(4 * i), 32'(255 - img[i]), err);
    apb_write(conv_cfg_pkg::addr_ctrl, 32'h1, err);
    wait_done("busy ignored");
    compare_results("busy ignored");
    apb_write(conv_cfg_pkg::res_base, 32'h5A5A5, err);
    expect_slverr("result write", 1'b1, err);
    apb_read(conv_cfg_pkg::res_base, word, err);
    check_word("result after write", model_conv(0, 0), word);
endtask

`endif

// ==== bench/conv_tb.sv ====
module conv_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period  = 8;
    localparam int n_tests     = 5;
    localparam int watchdog_ns = n_tests * 2000 * clk_period;
    localparam int max_polls   = 200;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [conv_cfg_pkg::apb_aw-1:0] paddr;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [conv_cfg_pkg::apb_dw-1:0] pwdata;
    logic [conv_cfg_pkg::apb_dw-1:0] prdata;
    logic                            pready;
    logic                            pslverr;

    int value_errors = 0;
    int other_errors = 0;

    // image and run settings shared by the tests and the model
    int                                img [conv_dp_pkg::n_pix];
    logic [conv_cfg_pkg::wt_bits-1:0]  wts;
    logic [conv_dp_pkg::scale_w-1:0]   scl;

    conv_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // apb driver
    //////////////////////////////////////////////////

    task automatic apb_access(input logic [conv_cfg_pkg::apb_aw-1:0] addr, input logic write,
                              input logic [conv_cfg_pkg::apb_dw-1:0] wdata,
                              output logic [conv_cfg_pkg::apb_dw-1:0] rdata, output logic err);
        @(negedge clk);
        paddr   = addr; // setup phase
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #2; // mid access phase
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1)
        begin
            $display("pready was not high in the access phase at %0t", $time);
            other_errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [conv_cfg_pkg::apb_aw-1:0] addr,
                             input logic [conv_cfg_pkg::apb_dw-1:0] data, output logic err);
        logic [conv_cfg_pkg::apb_dw-1:0] unused;
        apb_access(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input logic [conv_cfg_pkg::apb_aw-1:0] addr,
                            output logic [conv_cfg_pkg::apb_dw-1:0] data, output logic err);
        apb_access(addr, 1'b0, '0, data, err);
    endtask

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [conv_cfg_pkg::apb_dw-1:0] expected,
                              input logic [conv_cfg_pkg::apb_dw-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_res(input string name,
                             input logic signed [conv_dp_pkg::res_w-1:0] expected,
                             input logic signed [conv_dp_pkg::res_w-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic expect_slverr(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected pslverr %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    `include "conv_tests.svh"

    initial
    begin
        #(watchdog_ns);
        $display("timeout: run still going after %0d ns", watchdog_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(75));
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        wts     = '0;
        scl     = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_regs();
        test_centre_ramp();
        test_random_image();
        test_most_negative();
        test_busy_ignored();

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+bench
src/conv_dp_pkg.sv
src/conv_cfg_pkg.sv
src/conv_regs.sv
src/feature_scan.sv
src/window_buffer.sv
src/ternary_mac.sv
src/conv_top.sv
bench/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the conv testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f vlog.f -o conv_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/conv_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    exit 1
fi
grep -q "Simulation finished: PASS" "$log" || exit 1
exit 0
